// ==== hop_codes.mem ====
// one 16-bit hop code per line in hex, table entry 0 first
A5C3
1E0F
7B2D
C4E1
3F96
8D5A
0F71
E2B8

// ==== list.f ====
source/tag_rx_pkg.sv
source/iq_scaler.sv
source/preamble_detect.sv
source/sync_timer.sv
source/rx_state_ctrl.sv
source/rx_out_stage.sv
source/hop_scan_shifter.sv
source/tag_rx_top.sv
tests/tag_rx_tb.sv

// ==== source/hop_scan_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module hop_scan_shifter #(
  parameter int HOP_BITS = 16,
  parameter int NUM_HOPS = 8,
  parameter int SCAN_DIV = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic hop_start,
  output logic scan_busy,
  output logic scan_phi,
  output logic scan_data,
  output logic scan_load
);

  localparam int IDX_W = (NUM_HOPS > 1) ? $clog2(NUM_HOPS) : 1;
  localparam int BIT_W = (HOP_BITS > 1) ? $clog2(HOP_BITS) : 1;
  localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [HOP_BITS-1:0] hop_rom [NUM_HOPS];
  logic [IDX_W-1:0]    hop_idx;
  logic [HOP_BITS-1:0] shift_reg;
  logic [BIT_W-1:0]    bit_cnt;
  logic [DIV_W-1:0]    div_cnt;
  logic                tick;

  initial begin
    $readmemh("hop_codes.mem", hop_rom);
  end

  // clock enable, one tick per scan half-period
  assign tick = (div_cnt == DIV_W'(SCAN_DIV - 1));

  // msb first, quiet while loading
  assign scan_data = scan_busy & ~scan_load & shift_reg[HOP_BITS-1];

  always_ff @(posedge clk) begin
    if (reset || !scan_busy || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      scan_busy <= 1'b0;
      scan_phi  <= 1'b0;
      scan_load <= 1'b0;
      bit_cnt   <= '0;
      hop_idx   <= '0;
    end else if (!scan_busy) begin
      if (hop_start) begin
        scan_busy <= 1'b1;
        bit_cnt   <= '0;
      end
    end else if (tick) begin
      if (scan_load) begin
        // load done, move on to the next code
        scan_load <= 1'b0;
        scan_busy <= 1'b0;
        hop_idx   <= (hop_idx == IDX_W'(NUM_HOPS - 1)) ? '0 : hop_idx + 1'b1;
      end else if (!scan_phi) begin
        scan_phi <= 1'b1;
      end else begin
        scan_phi <= 1'b0;
        if (bit_cnt == BIT_W'(HOP_BITS - 1)) begin
          scan_load <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // next bit is set up as phi falls
  always_ff @(posedge clk) begin
    if (!scan_busy && hop_start) begin
      shift_reg <= hop_rom[hop_idx];
    end else if (scan_busy && tick && scan_phi) begin
      shift_reg <= shift_reg << 1;
    end
  end

endmodule

`default_nettype wire

// ==== source/iq_scaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_scaler import tag_rx_pkg::*; #(
  parameter int SCALE_SHIFT = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  logic [DATA_W-1:0] scale_val,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic [DATA_W-1:0] in_i,
  input  logic [DATA_W-1:0] in_q,
  output logic              s_valid,
  input  logic              s_ready,
  output logic [DATA_W-1:0] s_i,
  output logic [DATA_W-1:0] s_q
);

  localparam int PROD_W = 2 * DATA_W + 1;
  localparam logic signed [PROD_W-1:0] SAT_MAX = (1 <<< (DATA_W - 1)) - 1;
  localparam logic signed [PROD_W-1:0] SAT_MIN = -(1 <<< (DATA_W - 1));

  logic [DATA_W-1:0]        scale_reg;
  logic signed [PROD_W-1:0] prod_i;
  logic signed [PROD_W-1:0] prod_q;

  function automatic logic [DATA_W-1:0] saturate(input logic signed [PROD_W-1:0] p);
    logic signed [PROD_W-1:0] sh;
    sh = p >>> SCALE_SHIFT;
    if (sh > SAT_MAX) begin
      return DATA_W'(SAT_MAX);
    end else if (sh < SAT_MIN) begin
      return DATA_W'(SAT_MIN);
    end
    return DATA_W'(sh);
  endfunction

  // a zero scale would blank the stream, so it counts as unity
  always_ff @(posedge clk) begin
    scale_reg <= (scale_val == '0) ? DATA_W'(1) : scale_val;
  end

  // scale factor is unsigned, samples are signed
  assign prod_i = $signed(in_i) * $signed({1'b0, scale_reg});
  assign prod_q = $signed(in_q) * $signed({1'b0, scale_reg});

  assign in_ready = s_ready | ~s_valid;

  always_ff @(posedge clk) begin
    if (clear) begin
      s_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      s_valid <= 1'b1;
    end else if (s_ready) begin
      s_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s_i <= saturate(prod_i);
      s_q <= saturate(prod_q);
    end
  end

endmodule

`default_nettype wire

// ==== source/preamble_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module preamble_detect import tag_rx_pkg::*; #(
  parameter int NRUN = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  logic              s_valid,
  input  logic              s_ready,
  input  logic [DATA_W-1:0] s_i,
  input  logic [DATA_W-1:0] s_q,
  input  logic [POW_W-1:0]  noise_thres,
  output logic              peak_stb
);

  localparam int RUN_W = $clog2(NRUN + 1);

  logic                       xfer;
  logic signed [2*DATA_W-1:0] sq_i;
  logic signed [2*DATA_W-1:0] sq_q;
  logic [POW_W-1:0]           power;
  logic                       loud;
  logic [RUN_W-1:0]           run_cnt;

  // only watches the scaled stream, never stalls it
  assign xfer = s_valid & s_ready;

  // instantaneous power, i^2 + q^2
  assign sq_i  = $signed(s_i) * $signed(s_i);
  assign sq_q  = $signed(s_q) * $signed(s_q);
  assign power = POW_W'($unsigned(sq_i)) + POW_W'($unsigned(sq_q));
  assign loud  = power > noise_thres;

  always_ff @(posedge clk) begin
    if (clear) begin
      run_cnt  <= '0;
      peak_stb <= 1'b0;
    end else begin
      peak_stb <= 1'b0;
      if (xfer) begin
        if (!loud) begin
          run_cnt <= '0;
        end else if (run_cnt == RUN_W'(NRUN - 1)) begin
          // run complete, strobe and start over
          run_cnt  <= '0;
          peak_stb <= 1'b1;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rx_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_out_stage import tag_rx_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  logic              s_valid,
  output logic              s_ready,
  input  logic [DATA_W-1:0] s_i,
  input  logic [DATA_W-1:0] s_q,
  input  logic              sync_mode,
  input  logic              rx_mode,
  input  logic              half_done,
  output logic              sample_taken,
  output logic              out_valid,
  input  logic              out_ready,
  output logic [DATA_W-1:0] out_i,
  output logic [DATA_W-1:0] out_q
);

  localparam logic [DATA_W-1:0] SYNC_POS = DATA_W'(SYNC_AMP);
  localparam logic [DATA_W-1:0] SYNC_NEG = DATA_W'(-SYNC_AMP);

  logic hold;
  logic sync_sel;

  assign hold     = sync_mode & rx_mode;
  assign sync_sel = sync_mode & ~rx_mode;

  // slot takes a sample when empty or draining
  assign s_ready      = ~hold & (out_ready | ~out_valid);
  assign sample_taken = s_valid & s_ready;

  always_ff @(posedge clk) begin
    if (clear) begin
      out_valid <= 1'b0;
    end else if (sample_taken) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // sync burst: +amp then -amp on I, Q silent
  always_ff @(posedge clk) begin
    if (sample_taken) begin
      if (sync_sel) begin
        out_i <= half_done ? SYNC_NEG : SYNC_POS;
        out_q <= '0;
      end else begin
        out_i <= s_i;
        out_q <= s_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rx_state_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_state_ctrl import tag_rx_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      clear,
  input  logic      peak_stb,
  input  logic      window_done,
  input  logic      scan_busy,
  output rx_state_t state,
  output logic      timer_start,
  output logic      sync_mode,
  output logic      rx_mode,
  output logic      hop_start
);

  logic busy_q;

  // timer arms on the same edge the state leaves idle
  assign timer_start = (state == st_idle) & peak_stb;

  // both modes high mark the hop gap, output stage stalls then
  assign sync_mode = (state == st_sync) | (state == st_hop);
  assign rx_mode   = (state == st_rx) | (state == st_hop);

  always_ff @(posedge clk) begin
    if (clear) begin
      state     <= st_idle;
      hop_start <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      hop_start <= 1'b0;
      busy_q    <= scan_busy;
      case (state)
        st_idle: begin
          if (peak_stb) begin
            state <= st_sync;
          end
        end
        st_sync: begin
          if (window_done) begin
            state <= st_rx;
          end
        end
        st_rx: begin
          if (window_done) begin
            state     <= st_hop;
            hop_start <= 1'b1;
          end
        end
        st_hop: begin
          // wait for the falling edge of busy
          if (busy_q && !scan_busy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/sync_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_timer #(
  parameter int SYNC_LEN = 32,
  parameter int RX_LEN   = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clear,
  input  logic        timer_start,
  input  logic        sample_taken,
  output logic [15:0] sample_idx,
  output logic        half_done,
  output logic        window_done
);

  logic active;

  // sample_idx is the index of the sample being taken right now
  assign half_done   = sample_idx >= 16'(SYNC_LEN / 2);
  assign window_done = active & sample_taken &
                       ((sample_idx == 16'(SYNC_LEN - 1)) ||
                        (sample_idx == 16'(SYNC_LEN + RX_LEN - 1)));

  always_ff @(posedge clk) begin
    if (clear) begin
      active     <= 1'b0;
      sample_idx <= '0;
    end else if (timer_start) begin
      active     <= 1'b1;
      sample_idx <= '0;
    end else if (active && sample_taken) begin
      if (sample_idx == 16'(SYNC_LEN + RX_LEN - 1)) begin
        active     <= 1'b0;
        sample_idx <= '0;
      end else begin
        sample_idx <= sample_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/tag_rx_pkg.sv ====
`default_nettype none

package tag_rx_pkg;

  // controller states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_sync = 2'd1,
    st_rx   = 2'd2,
    st_hop  = 2'd3
  } rx_state_t;

  // sample and power widths
  localparam int DATA_W = 16;
  localparam int POW_W  = 32;

  // sync burst magnitude, I only
  localparam int SYNC_AMP = 16384;

  // front panel gpio word and its fixed bit positions
  localparam int GPIO_W        = 12;
  localparam int GPIO_SYNC_BIT = 0;
  localparam int GPIO_LOAD_BIT = 2;
  localparam int GPIO_DATA_BIT = 4;
  localparam int GPIO_PHI_BIT  = 8;
  localparam int GPIO_ID_BIT   = 10;

endpackage

`default_nettype wire

// ==== source/tag_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_rx_top import tag_rx_pkg::*; #(
  parameter int SCALE_SHIFT = 8,
  parameter int NRUN        = 8,
  parameter int SYNC_LEN    = 32,
  parameter int RX_LEN      = 64,
  parameter int HOP_BITS    = 16,
  parameter int NUM_HOPS    = 8,
  parameter int SCAN_DIV    = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              run_rx,
  input  logic [DATA_W-1:0] scale_val,
  input  logic [POW_W-1:0]  noise_thres,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic [DATA_W-1:0] in_i,
  input  logic [DATA_W-1:0] in_q,
  output logic              out_valid,
  input  logic              out_ready,
  output logic [DATA_W-1:0] out_i,
  output logic [DATA_W-1:0] out_q,
  output rx_state_t         rx_state,
  output logic              peak_detect,
  output logic [GPIO_W-1:0] fp_gpio_out
);

  logic              clear;
  logic              s_valid;
  logic              s_ready;
  logic [DATA_W-1:0] s_i;
  logic [DATA_W-1:0] s_q;
  logic              peak_stb;
  logic              timer_start;
  logic              sync_mode;
  logic              rx_mode;
  logic              sample_taken;
  logic              half_done;
  logic              window_done;
  logic              hop_start;
  logic              scan_busy;
  logic              scan_phi;
  logic              scan_data;
  logic              scan_load;
  logic [GPIO_W-1:0] gpio_next;

  // run_rx low restarts everything but the hop sequence
  assign clear = reset | ~run_rx;

  // strobes outside idle are ignored by the controller
  assign peak_detect = peak_stb & (rx_state == st_idle);

  iq_scaler #(.SCALE_SHIFT(SCALE_SHIFT)) i_iq_scaler (
    .clk(clk), .reset(reset), .clear(clear), .scale_val(scale_val),
    .in_valid(in_valid), .in_ready(in_ready), .in_i(in_i), .in_q(in_q),
    .s_valid(s_valid), .s_ready(s_ready), .s_i(s_i), .s_q(s_q)
  );

  preamble_detect #(.NRUN(NRUN)) i_preamble_detect (
    .clk(clk), .reset(reset), .clear(clear),
    .s_valid(s_valid), .s_ready(s_ready), .s_i(s_i), .s_q(s_q),
    .noise_thres(noise_thres), .peak_stb(peak_stb)
  );

  sync_timer #(.SYNC_LEN(SYNC_LEN), .RX_LEN(RX_LEN)) i_sync_timer (
    .clk(clk), .reset(reset), .clear(clear), .timer_start(timer_start),
    .sample_taken(sample_taken), .sample_idx(),
    .half_done(half_done), .window_done(window_done)
  );

  rx_state_ctrl i_rx_state_ctrl (
    .clk(clk), .reset(reset), .clear(clear), .peak_stb(peak_stb),
    .window_done(window_done), .scan_busy(scan_busy), .state(rx_state),
    .timer_start(timer_start), .sync_mode(sync_mode), .rx_mode(rx_mode),
    .hop_start(hop_start)
  );

  rx_out_stage i_rx_out_stage (
    .clk(clk), .reset(reset), .clear(clear),
    .s_valid(s_valid), .s_ready(s_ready), .s_i(s_i), .s_q(s_q),
    .sync_mode(sync_mode), .rx_mode(rx_mode), .half_done(half_done),
    .sample_taken(sample_taken),
    .out_valid(out_valid), .out_ready(out_ready), .out_i(out_i), .out_q(out_q)
  );

  hop_scan_shifter #(
    .HOP_BITS(HOP_BITS), .NUM_HOPS(NUM_HOPS), .SCAN_DIV(SCAN_DIV)
  ) i_hop_scan_shifter (
    .clk(clk), .reset(reset), .hop_start(hop_start), .scan_busy(scan_busy),
    .scan_phi(scan_phi), .scan_data(scan_data), .scan_load(scan_load)
  );

  // gpio word, scan busy goes out on the id line
  always_comb begin
    gpio_next                = '0;
    gpio_next[GPIO_SYNC_BIT] = (rx_state == st_sync);
    gpio_next[GPIO_LOAD_BIT] = scan_load;
    gpio_next[GPIO_DATA_BIT] = scan_data;
    gpio_next[GPIO_PHI_BIT]  = scan_phi;
    gpio_next[GPIO_ID_BIT]   = scan_busy;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fp_gpio_out <= '0;
    end else begin
      fp_gpio_out <= gpio_next;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tag_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_rx_tb import tag_rx_pkg::*; ;

  localparam int SCALE_SHIFT = 8;
  localparam int NRUN        = 8;
  localparam int SYNC_LEN    = 32;
  localparam int RX_LEN      = 64;
  localparam int HOP_BITS    = 16;
  localparam int NUM_HOPS    = 8;
  localparam int SCAN_DIV    = 4;
  localparam int WINDOW      = SYNC_LEN + RX_LEN;
  localparam int SEED        = 56367;

  // upper bounds on what the tests send: 300 plain samples, 11 bursts, 10 scans
  localparam int TOTAL_SAMPLES = 300 + 11 * (40 + NRUN + WINDOW);
  localparam int NUM_SCANS     = 10;
  localparam int SCAN_CYCLES   = (2 * HOP_BITS + 2) * SCAN_DIV;
  localparam int MAX_CYCLES    = 4 * TOTAL_SAMPLES + NUM_SCANS * SCAN_CYCLES + 200;

  logic              clk;
  logic              reset;
  logic              run_rx;
  logic [DATA_W-1:0] scale_val;
  logic [POW_W-1:0]  noise_thres;
  logic              in_valid;
  logic              in_ready;
  logic [DATA_W-1:0] in_i;
  logic [DATA_W-1:0] in_q;
  logic              out_valid;
  logic              out_ready;
  logic [DATA_W-1:0] out_i;
  logic [DATA_W-1:0] out_q;
  rx_state_t         rx_state;
  logic              peak_detect;
  logic [GPIO_W-1:0] fp_gpio_out;

  // samples waiting to be sent, and predicted outputs
  logic [DATA_W-1:0] send_i[$];
  logic [DATA_W-1:0] send_q[$];
  logic [DATA_W-1:0] exp_i[$];
  logic [DATA_W-1:0] exp_q[$];
  int                exp_sync[$];

  logic [HOP_BITS-1:0] hop_table [NUM_HOPS];
  logic [HOP_BITS-1:0] scan_word;

  // model state: 0 idle, 1 sync, 2 rx
  int m_phase = 0;
  int m_cnt = 0;
  int m_run = 0;
  bit pause = 0;
  int pause_wait = 0;
  bit stall_out = 0;
  int peaks_exp = 0;
  int peaks_seen = 0;
  int hops_exp = 0;
  int scans_done = 0;
  int scan_idx = 0;
  int scan_bits = 0;
  bit phi_q = 0;
  bit load_q = 0;
  int in_pct = 80;
  int out_pct = 70;
  int errors = 0;
  int test_errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  tag_rx_top #(
    .SCALE_SHIFT(SCALE_SHIFT), .NRUN(NRUN), .SYNC_LEN(SYNC_LEN), .RX_LEN(RX_LEN),
    .HOP_BITS(HOP_BITS), .NUM_HOPS(NUM_HOPS), .SCAN_DIV(SCAN_DIV)
  ) i_tag_rx_top (
    .clk(clk), .reset(reset), .run_rx(run_rx), .scale_val(scale_val),
    .noise_thres(noise_thres), .in_valid(in_valid), .in_ready(in_ready),
    .in_i(in_i), .in_q(in_q), .out_valid(out_valid), .out_ready(out_ready),
    .out_i(out_i), .out_q(out_q), .rx_state(rx_state), .peak_detect(peak_detect),
    .fp_gpio_out(fp_gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("Error: timeout after %0d cycles, the DUT stopped making progress", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      $display("Fail %s exp %h got %h", name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    errors++;
    test_errors++;
  endtask

  // scale rule: max(scale, 1) times sample, arithmetic shift, saturate
  function automatic logic [DATA_W-1:0] scale_sample(input logic [DATA_W-1:0] x,
                                                     input logic [DATA_W-1:0] sc);
    longint factor;
    longint prod;
    factor = (sc == 0) ? 64'sd1 : longint'(sc);
    prod = longint'($signed(x)) * factor;
    prod = prod >>> SCALE_SHIFT;
    if (prod > 32767) begin
      prod = 32767;
    end else if (prod < -32768) begin
      prod = -32768;
    end
    return DATA_W'(prod);
  endfunction

  // one accepted input, in stream order
  task automatic model_accept(input logic [DATA_W-1:0] xi, input logic [DATA_W-1:0] xq);
    logic [DATA_W-1:0] si;
    logic [DATA_W-1:0] sq;
    longint a;
    longint b;
    bit loud;
    bit was_idle;
    si = scale_sample(xi, scale_val);
    sq = scale_sample(xq, scale_val);
    a = longint'($signed(si));
    b = longint'($signed(sq));
    loud = (a * a + b * b) > longint'(noise_thres);
    was_idle = (m_phase == 0);
    if (m_phase == 1) begin
      exp_i.push_back((m_cnt < SYNC_LEN / 2) ? DATA_W'(SYNC_AMP) : DATA_W'(-SYNC_AMP));
      exp_q.push_back('0);
      // gpio lags a cycle, so the last sync output is not checked
      exp_sync.push_back((m_cnt < SYNC_LEN - 1) ? 1 : -1);
      m_cnt++;
      if (m_cnt == SYNC_LEN) begin
        m_phase = 2;
        m_cnt = 0;
      end
    end else begin
      exp_i.push_back(si);
      exp_q.push_back(sq);
      exp_sync.push_back((m_phase == 2) ? 0 : -1);
      if (m_phase == 2) begin
        m_cnt++;
        if (m_cnt == RX_LEN) begin
          m_phase = 0;
          hops_exp++;
        end
      end
    end
    if (!loud) begin
      m_run = 0;
    end else if (m_run == NRUN - 1) begin
      m_run = 0;
      if (was_idle) begin
        m_phase = 1;
        m_cnt = 0;
        peaks_exp++;
        pause = 1;
        pause_wait = 0;
      end
    end else begin
      m_run++;
    end
  endtask

  // one clock: observe at the edge, then drive the next inputs
  task automatic next_cycle();
    logic [GPIO_W-1:0] g;
    @(posedge clk);
    g = fp_gpio_out;
    if (peak_detect === 1'b1) begin
      peaks_seen++;
      if (pause) begin
        pause = 0;
      end else begin
        report_error("peak_detect pulsed where no preamble was expected");
      end
    end else if (pause) begin
      pause_wait++;
      if (pause_wait > 64) begin
        report_error("peak_detect never pulsed after a complete preamble");
        pause = 0;
      end
    end
    if (in_valid && in_ready) begin
      model_accept(in_i, in_q);
      void'(send_i.pop_front());
      void'(send_q.pop_front());
    end
    if (out_valid && out_ready) begin
      if (exp_i.size() == 0) begin
        report_error("output transfer with no sample expected");
      end else begin
        check_value("out_i", exp_i.pop_front(), out_i);
        check_value("out_q", exp_q.pop_front(), out_q);
        if (exp_sync[0] >= 0) begin
          check_value("gpio_sync", 32'(exp_sync[0]), 32'(g[GPIO_SYNC_BIT]));
        end
        void'(exp_sync.pop_front());
      end
    end
    // scan port, data sampled on each phi rise
    if (g[GPIO_PHI_BIT] && !phi_q) begin
      check_value("gpio_id", 1, g[GPIO_ID_BIT]);
      scan_word = {scan_word[HOP_BITS-2:0], g[GPIO_DATA_BIT]};
      scan_bits++;
    end
    if (g[GPIO_LOAD_BIT] && !load_q) begin
      check_value("gpio_id", 1, g[GPIO_ID_BIT]);
      check_value("scan_bits", HOP_BITS, scan_bits);
      check_value("scan_code", hop_table[scan_idx], scan_word);
      scan_idx = (scan_idx + 1) % NUM_HOPS;
      scans_done++;
      scan_bits = 0;
    end
    // busy drops together with the load line
    if (!g[GPIO_LOAD_BIT] && load_q) begin
      check_value("gpio_id", 0, g[GPIO_ID_BIT]);
    end
    phi_q = g[GPIO_PHI_BIT];
    load_q = g[GPIO_LOAD_BIT];
    // a sample that is not yet taken stays on the bus
    if (!(in_valid && !in_ready)) begin
      if (send_i.size() > 0 && !pause && run_rx && ($urandom % 100) < in_pct) begin
        in_valid <= 1'b1;
        in_i <= send_i[0];
        in_q <= send_q[0];
      end else begin
        in_valid <= 1'b0;
      end
    end
    if (stall_out) begin
      out_ready <= 1'b0;
    end else begin
      out_ready <= (($urandom % 100) < out_pct);
    end
  endtask

  task automatic add_sample(input logic [DATA_W-1:0] xi, input logic [DATA_W-1:0] xq);
    send_i.push_back(xi);
    send_q.push_back(xq);
  endtask

  // well under a 1e6 power threshold at unity scale
  task automatic add_quiet(input int n);
    repeat (n) begin
      add_sample(DATA_W'(int'($urandom % 1001) - 500), DATA_W'(int'($urandom % 1001) - 500));
    end
  endtask

  task automatic add_loud(input int n);
    int m;
    repeat (n) begin
      m = 4000 + int'($urandom % 26001);
      add_sample(($urandom % 2) ? DATA_W'(-m) : DATA_W'(m),
                 DATA_W'(int'($urandom % 1001) - 500));
    end
  endtask

  // idle gap, a short run, then a full preamble and a window of filler
  task automatic add_burst(input bit short_run, input bit loud_filler, input int tail);
    add_quiet(10);
    if (short_run) begin
      add_loud(1 + int'($urandom % (NRUN - 1)));
      add_quiet(5);
    end
    add_loud(NRUN);
    repeat (WINDOW) begin
      if (loud_filler && ($urandom % 4) != 0) begin
        add_loud(1);
      end else begin
        add_quiet(1);
      end
    end
    add_quiet(tail);
  endtask

  task automatic drain_idle();
    while (send_i.size() != 0 || exp_i.size() != 0 || pause || rx_state != st_idle ||
           fp_gpio_out[GPIO_ID_BIT]) begin
      next_cycle();
    end
    repeat (4) next_cycle();
  endtask

  task automatic finish_test(input string name, input int bursts, input int peak_base);
    drain_idle();
    check_value("detections", bursts, peaks_seen - peak_base);
    check_value("peaks_model", peaks_exp, peaks_seen);
    check_value("scans", hops_exp, scans_done);
    check_value("rx_state", st_idle, rx_state);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %-10s %s (%0d errors)", tests_run, name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  initial begin
    int base;
    void'($urandom(SEED));
    reset = 1'b1;
    run_rx = 1'b1;
    scale_val = 16'd256;
    noise_thres = '1;
    in_valid = 1'b0;
    in_i = '0;
    in_q = '0;
    out_ready = 1'b0;
    scan_word = '0;
    $readmemh("hop_codes.mem", hop_table);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    next_cycle();
    check_value("out_valid", 0, out_valid);
    check_value("peak_detect", 0, peak_detect);
    check_value("fp_gpio_out", 0, fp_gpio_out);
    check_value("rx_state", st_idle, rx_state);

    // scaling, threshold out of reach
    base = peaks_seen;
    for (int blk = 0; blk < 3; blk++) begin
      scale_val <= (blk == 0) ? 16'd0 : (blk == 1) ? 16'($urandom) : 16'd256;
      repeat (2) next_cycle();
      repeat (100) add_sample(16'($urandom), 16'($urandom));
      drain_idle();
    end
    finish_test("scaling", 0, base);

    // detection, loud runs inside the window must not count
    base = peaks_seen;
    noise_thres <= 32'd1000000;
    repeat (2) next_cycle();
    add_burst(1'b1, 1'b1, 10);
    add_burst(1'b1, 1'b1, 10);
    finish_test("detect", 2, base);

    // sync insertion under heavy back-pressure
    base = peaks_seen;
    in_pct = 90;
    out_pct = 30;
    add_burst(1'b0, 1'b0, 10);
    finish_test("sync", 1, base);

    // back to back windows wrap the hop table
    base = peaks_seen;
    out_pct = 90;
    repeat (6) add_burst(1'b1, 1'b0, 4);
    finish_test("hop_scan", 6, base);

    // run_rx dropped partway into the receive window
    base = peaks_seen;
    out_pct = 70;
    add_quiet(10);
    add_loud(NRUN);
    add_quiet(SYNC_LEN + 20);
    while (send_i.size() != 0 || exp_i.size() != 0 || pause) begin
      next_cycle();
    end
    check_value("rx_state", st_rx, rx_state);
    // fill the output slot and the scaler stage before the drop
    stall_out = 1;
    add_quiet(2);
    while (send_i.size() != 0) begin
      next_cycle();
    end
    repeat (2) next_cycle();
    check_value("out_valid", 1, out_valid);
    run_rx <= 1'b0;
    repeat (3) next_cycle();
    check_value("out_valid", 0, out_valid);
    check_value("rx_state", st_idle, rx_state);
    // flushed samples never reach the output
    exp_i.delete();
    exp_q.delete();
    exp_sync.delete();
    stall_out = 0;
    run_rx <= 1'b1;
    m_phase = 0;
    m_cnt = 0;
    m_run = 0;
    repeat (2) next_cycle();
    add_burst(1'b0, 1'b0, 10);
    finish_test("run_rx", 2, base);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
